//--- compile.f
+incdir+include
hw/isa_pkg.sv
hw/ooo_pkg.sv
hw/map_table.sv
hw/rs_entry.sv
hw/reservation_station.sv
hw/ooo_dispatch.sv
test/tb_ooo_dispatch.sv

//--- test/tb_ooo_dispatch.sv
`default_nettype none

`include "rs_defines.svh"

module tb_ooo_dispatch;

        import isa_pkg::*;
        import ooo_pkg::*;

        // rough cycle count of the five tests, summed
        localparam int TEST_CYCLES = 8 + 12 + 10 + 26 + 16;
        localparam int WATCHDOG_CYCLES = TEST_CYCLES * 20;

        logic           clock = 1'b0;
        logic           rst = 1'b1;
        logic           dispatch_valid = 1'b0;
        id_packet_t     id_packet = '0;
        rob2rs_packet_t rob2rs_packet = '0;
        cdb_packet_t    cdb_packet = '0;
        retire_packet_t retire_packet = '0;
        logic           fu_ready = 1'b1;
        logic           rs_full;
        is_packet_t     is_packet;

        // reference model
        logic [`RS_LEN-1:0] m_busy;
        logic [`RS_LEN-1:0] m_wait1;
        logic [`RS_LEN-1:0] m_wait2;
        tag_t               m_tag1 [`RS_LEN];
        tag_t               m_tag2 [`RS_LEN];
        is_packet_t         m_pkt [`RS_LEN];
        tag_t               m_map_tag [`NUM_REGS];
        logic               m_map_rdy [`NUM_REGS];
        is_packet_t         exp_issue;

        data_t       tag_val [`ROB_LEN];
        tag_t        next_tag = 'd1;
        tag_t        last_tag;
        logic [15:0] lfsr_state = 16'd52169;
        string       test_name = "reset";
        int          errors = 0;
        int          test_err_base = 0;
        int          tests_run = 0;

        ooo_dispatch dut_i (
                .clock          (clock),
                .rst            (rst),
                .dispatch_valid (dispatch_valid),
                .id_packet      (id_packet),
                .rob2rs_packet  (rob2rs_packet),
                .cdb_packet     (cdb_packet),
                .retire_packet  (retire_packet),
                .fu_ready       (fu_ready),
                .rs_full        (rs_full),
                .is_packet      (is_packet)
        );

        always #5 clock = ~clock;

        // x^16 + x^14 + x^13 + x^11 + 1
        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        endfunction

        function automatic data_t rand_word(input int nbits);
                data_t w;
                w = '0;
                for (int i = 0; i < nbits; i++) begin
                        lfsr_state = lfsr_next(lfsr_state);
                        w = {w[`XLEN-2:0], lfsr_state[0]};
                end
                return w;
        endfunction

        function automatic int lowest_slot(input logic [`RS_LEN-1:0] mask);
                int idx;
                idx = -1;
                for (int s = `RS_LEN - 1; s >= 0; s--) begin
                        if (mask[s]) begin
                                idx = s;
                        end
                end
                return idx;
        endfunction

        function automatic tag_t src_tag(input reg_idx_t idx);
                return (idx == '0) ? '0 : m_map_tag[idx];
        endfunction

        // {waiting, value} of one operand at dispatch
        function automatic logic [`XLEN:0] capture_src(input reg_idx_t idx, input data_t rf_val,
                                                       input data_t rob_val);
                tag_t t;
                t = src_tag(idx);
                if (t == '0) begin
                        return {1'b0, rf_val};
                end else if (m_map_rdy[idx]) begin
                        return {1'b0, rob_val};
                end else if (cdb_packet.valid && cdb_packet.reg_tag == t) begin
                        return {1'b0, cdb_packet.reg_value};
                end
                return {1'b1, data_t'(0)};
        endfunction

        always @(posedge clock) begin
                int sel;
                int fr;
                logic [`XLEN:0] c1;
                logic [`XLEN:0] c2;
                if (rst) begin
                        m_busy = '0;
                        m_wait1 = '0;
                        m_wait2 = '0;
                        for (int r = 0; r < `NUM_REGS; r++) begin
                                m_map_tag[r] = '0;
                                m_map_rdy[r] = 1'b1;
                        end
                end else begin
                        sel = lowest_slot(m_busy & ~m_wait1 & ~m_wait2);
                        fr = lowest_slot(~m_busy);
                        for (int s = 0; s < `RS_LEN; s++) begin
                                if (cdb_packet.valid && m_wait1[s] && m_tag1[s] == cdb_packet.reg_tag) begin
                                        m_wait1[s] = 1'b0;
                                        m_pkt[s].rs1_value = cdb_packet.reg_value;
                                end
                                if (cdb_packet.valid && m_wait2[s] && m_tag2[s] == cdb_packet.reg_tag) begin
                                        m_wait2[s] = 1'b0;
                                        m_pkt[s].rs2_value = cdb_packet.reg_value;
                                end
                        end
                        if (sel >= 0 && fu_ready) begin
                                m_busy[sel] = 1'b0;
                        end
                        if (dispatch_valid && fr >= 0) begin
                                c1 = capture_src(id_packet.rs1_idx, id_packet.rs1_value,
                                                 rob2rs_packet.rs1_value);
                                c2 = capture_src(id_packet.rs2_idx, id_packet.rs2_value,
                                                 rob2rs_packet.rs2_value);
                                m_busy[fr] = 1'b1;
                                m_wait1[fr] = c1[`XLEN];
                                m_wait2[fr] = c2[`XLEN];
                                m_tag1[fr] = src_tag(id_packet.rs1_idx);
                                m_tag2[fr] = src_tag(id_packet.rs2_idx);
                                m_pkt[fr] = '{valid: 1'b1, inst: id_packet.inst, op: id_packet.op,
                                              rs1_value: c1[`XLEN-1:0], rs2_value: c2[`XLEN-1:0],
                                              dest_tag: rob2rs_packet.rob_entry};
                        end
                        for (int r = 1; r < `NUM_REGS; r++) begin
                                if (cdb_packet.valid && m_map_tag[r] == cdb_packet.reg_tag) begin
                                        m_map_rdy[r] = 1'b1;
                                end
                                if (retire_packet.valid && retire_packet.reg_idx == reg_idx_t'(r)
                                    && m_map_tag[r] == retire_packet.tag) begin
                                        m_map_tag[r] = '0;
                                        m_map_rdy[r] = 1'b1;
                                end
                        end
                        if (dispatch_valid && fr >= 0 && id_packet.dest_reg_idx != '0) begin
                                m_map_tag[id_packet.dest_reg_idx] = rob2rs_packet.rob_entry;
                                m_map_rdy[id_packet.dest_reg_idx] = 1'b0;
                        end
                end
        end

        // lowest ready model slot
        always_comb begin
                int sel;
                sel = lowest_slot(m_busy & ~m_wait1 & ~m_wait2);
                exp_issue = '0;
                if (sel >= 0) begin
                        exp_issue = m_pkt[sel];
                end
        end

        task automatic report_mismatch(input string what, input logic [127:0] exp,
                                       input logic [127:0] act);
                errors++;
                $display("FAILED %s %s expected %h actual %h", test_name, what, exp, act);
        endtask

        a_issue_valid: assert property (@(posedge clock) disable iff (rst)
                is_packet.valid == exp_issue.valid)
                else report_mismatch("issue valid", $sampled(exp_issue.valid),
                                     $sampled(is_packet.valid));

        // also covers the hold under back-pressure
        a_issue_packet: assert property (@(posedge clock) disable iff (rst)
                is_packet.valid |-> is_packet == exp_issue)
                else report_mismatch("issue packet", $sampled(exp_issue), $sampled(is_packet));

        a_full: assert property (@(posedge clock) disable iff (rst) rs_full == &m_busy)
                else report_mismatch("rs_full", $sampled(&m_busy), $sampled(rs_full));

        task automatic tick();
                @(posedge clock);
                #1;
                dispatch_valid = 1'b0;
                cdb_packet.valid = 1'b0;
                retire_packet.valid = 1'b0;
        endtask

        task automatic idle(input int n);
                repeat (n) tick();
        endtask

        task automatic set_dispatch(input int rs1, input int rs2, input int rd);
                dispatch_valid = 1'b1;
                id_packet.inst = rand_word(32);
                id_packet.op = fu_op_e'(3'(rand_word(3)));
                id_packet.rs1_idx = reg_idx_t'(rs1);
                id_packet.rs2_idx = reg_idx_t'(rs2);
                id_packet.dest_reg_idx = reg_idx_t'(rd);
                id_packet.rs1_value = rand_word(32);
                id_packet.rs2_value = rand_word(32);
                rob2rs_packet.rob_entry = next_tag;
                rob2rs_packet.rs1_value = tag_val[m_map_tag[rs1]];
                rob2rs_packet.rs2_value = tag_val[m_map_tag[rs2]];
                last_tag = next_tag;
                // tag 0 stays reserved for the register file
                next_tag = (next_tag == tag_t'(`ROB_LEN - 1)) ? tag_t'(1) : next_tag + 1'b1;
        endtask

        task automatic set_cdb(input tag_t tag);
                tag_val[tag] = rand_word(32);
                cdb_packet.valid = 1'b1;
                cdb_packet.reg_tag = tag;
                cdb_packet.reg_value = tag_val[tag];
        endtask

        task automatic set_retire(input int rd, input tag_t tag);
                retire_packet.valid = 1'b1;
                retire_packet.reg_idx = reg_idx_t'(rd);
                retire_packet.tag = tag;
        endtask

        task automatic drain(input int limit);
                int n;
                n = 0;
                while ((m_busy != '0 || is_packet.valid) && n < limit) begin
                        tick();
                        n++;
                end
                if (m_busy != '0 || is_packet.valid) begin
                        errors++;
                        $display("%s: station still busy after %0d cycles", test_name, limit);
                end
        endtask

        task automatic begin_test(input string name);
                test_name = name;
                test_err_base = errors;
        endtask

        task automatic end_test();
                tests_run++;
                if (errors == test_err_base) begin
                        $display("test %-16s ok", test_name);
                end else begin
                        $display("test %-16s %0d errors", test_name, errors - test_err_base);
                end
        endtask

        initial begin
                tag_t first_tag;
                tag_t wake_tag;
                for (int t = 0; t < `ROB_LEN; t++) begin
                        tag_val[t] = '0;
                end
                repeat (5) @(posedge clock);
                #1;
                rst = 1'b0;

                begin_test("rf_operands");
                set_dispatch(1, 2, 5);
                tick();
                drain(10);
                end_test();

                begin_test("cdb_wakeup");
                set_dispatch(6, 7, 8);
                first_tag = last_tag;
                tick();
                set_dispatch(8, 0, 20);
                idle(4);
                set_cdb(first_tag);
                tick();
                // tag now ready in the map so the rob supplies it
                set_dispatch(8, 3, 21);
                tick();
                drain(10);
                end_test();

                begin_test("same_cycle_cdb");
                set_dispatch(1, 2, 9);
                first_tag = last_tag;
                tick();
                set_dispatch(9, 9, 22);
                set_cdb(first_tag);
                tick();
                set_retire(9, first_tag);
                tick();
                set_dispatch(9, 1, 23);
                tick();
                drain(10);
                end_test();

                begin_test("full_and_drain");
                set_dispatch(1, 2, 10);
                first_tag = last_tag;
                tick();
                for (int i = 0; i < `RS_LEN; i++) begin
                        set_dispatch(10, 3, 11 + i);
                        tick();
                end
                // dropped while full
                set_dispatch(1, 2, 19);
                idle(3);
                set_cdb(first_tag);
                tick();
                drain(2 * `RS_LEN);
                end_test();

                begin_test("back_pressure");
                fu_ready = 1'b0;
                wake_tag = m_map_tag[5];
                set_dispatch(5, 0, 24);
                tick();
                set_dispatch(1, 2, 25);
                tick();
                set_dispatch(3, 4, 26);
                idle(5);
                set_cdb(wake_tag);
                idle(3);
                fu_ready = 1'b1;
                drain(10);
                end_test();

                $display("tests run %0d, errors %0d", tests_run, errors);
                if (errors == 0) begin
                        $display("ALL CHECKS PASSED");
                end else begin
                        $display("CHECKS FAILED");
                end
                $finish;
        end

        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge clock);
                $display("watchdog: run still going after %0d cycles", WATCHDOG_CYCLES);
                $display("CHECKS FAILED");
                $finish;
        end

endmodule

`default_nettype wire

//--- hw/ooo_dispatch.sv
`default_nettype none

`include "rs_defines.svh"

module ooo_dispatch (
        input  logic                    clock,
        input  logic                    rst,
        input  logic                    dispatch_valid,
        input  ooo_pkg::id_packet_t     id_packet,
        input  ooo_pkg::rob2rs_packet_t rob2rs_packet,
        input  ooo_pkg::cdb_packet_t    cdb_packet,
        input  ooo_pkg::retire_packet_t retire_packet,
        input  logic                    fu_ready,
        output logic                    rs_full,
        output ooo_pkg::is_packet_t     is_packet
);

        import ooo_pkg::*;

        mt2rs_packet_t mt2rs_packet;
        logic          dispatch_fire;

        // rename uses the tag the rob allocates for this dispatch
        map_table map_table_i (
                .clock         (clock),
                .rst           (rst),
                .dispatch_fire (dispatch_fire),
                .id_packet     (id_packet),
                .rob_tag       (rob2rs_packet.rob_entry),
                .cdb_packet    (cdb_packet),
                .retire_packet (retire_packet),
                .mt2rs_packet  (mt2rs_packet)
        );

        reservation_station rs_i (
                .clock          (clock),
                .rst            (rst),
                .dispatch_valid (dispatch_valid),
                .id_packet      (id_packet),
                .mt2rs_packet   (mt2rs_packet),
                .rob2rs_packet  (rob2rs_packet),
                .cdb_packet     (cdb_packet),
                .fu_ready       (fu_ready),
                .dispatch_fire  (dispatch_fire),
                .rs_full        (rs_full),
                .is_packet      (is_packet)
        );

endmodule

`default_nettype wire

//--- hw/reservation_station.sv
`default_nettype none

`include "rs_defines.svh"

module reservation_station (
        input  logic                    clock,
        input  logic                    rst,
        input  logic                    dispatch_valid,
        input  ooo_pkg::id_packet_t     id_packet,
        input  ooo_pkg::mt2rs_packet_t  mt2rs_packet,
        input  ooo_pkg::rob2rs_packet_t rob2rs_packet,
        input  ooo_pkg::cdb_packet_t    cdb_packet,
        input  logic                    fu_ready,
        output logic                    dispatch_fire,
        output logic                    rs_full,
        output ooo_pkg::is_packet_t     is_packet
);

        import ooo_pkg::*;

        logic [`RS_LEN-1:0]       load_en;
        logic [`RS_LEN-1:0]       clear_en;
        logic [`RS_LEN-1:0]       busy;
        logic [`RS_LEN-1:0]       ready;
        is_packet_t [`RS_LEN-1:0] entry_packets;
        logic [`RS_IDX_W-1:0]     issue_idx;

        assign rs_full       = &busy;
        assign dispatch_fire = dispatch_valid && !rs_full;

        // lowest free slot, scanned downward so the last hit wins
        always_comb begin
                load_en = '0;
                for (int i = `RS_LEN - 1; i >= 0; i--) begin
                        if (!busy[i]) begin
                                load_en    = '0;
                                load_en[i] = dispatch_fire;
                        end
                end
        end

        // lowest ready slot
        always_comb begin
                issue_idx = '0;
                for (int i = `RS_LEN - 1; i >= 0; i--) begin
                        if (ready[i]) begin
                                issue_idx = `RS_IDX_W'(i);
                        end
                end
        end

        always_comb begin
                clear_en            = '0;
                clear_en[issue_idx] = fu_ready && ready[issue_idx];
        end

        // valid comes straight from the selected entry, low when nothing is ready
        assign is_packet = entry_packets[issue_idx];

        for (genvar g = 0; g < `RS_LEN; g++) begin : g_entry
                rs_entry entry_i (
                        .clock         (clock),
                        .rst           (rst),
                        .load          (load_en[g]),
                        .id_packet     (id_packet),
                        .mt2rs_packet  (mt2rs_packet),
                        .rob2rs_packet (rob2rs_packet),
                        .cdb_packet    (cdb_packet),
                        .clear         (clear_en[g]),
                        .busy          (busy[g]),
                        .ready         (ready[g]),
                        .entry_packet  (entry_packets[g])
                );
        end

        a_load_onehot: assert property (@(posedge clock) disable iff (rst)
                $onehot0(load_en));

        // issued slot was ready and is free in the next cycle
        a_issue_ready: assert property (@(posedge clock) disable iff (rst)
                (is_packet.valid && fu_ready) |-> ready[issue_idx] ##1 !busy[$past(issue_idx)]);

endmodule

`default_nettype wire

//--- hw/rs_entry.sv
`default_nettype none

`include "rs_defines.svh"

module rs_entry (
        input  logic                    clock,
        input  logic                    rst,
        input  logic                    load,
        input  ooo_pkg::id_packet_t     id_packet,
        input  ooo_pkg::mt2rs_packet_t  mt2rs_packet,
        input  ooo_pkg::rob2rs_packet_t rob2rs_packet,
        input  ooo_pkg::cdb_packet_t    cdb_packet,
        input  logic                    clear,
        output logic                    busy,
        output logic                    ready,
        output ooo_pkg::is_packet_t     entry_packet
);

        import isa_pkg::*;
        import ooo_pkg::*;

        typedef struct packed {
                logic  valid;
                tag_t  tag;
                data_t value;
        } opnd_t;

        rs_state_e state_q;
        rs_state_e state_d;
        opnd_t     opnd1_q;
        opnd_t     opnd1_d;
        opnd_t     opnd2_q;
        opnd_t     opnd2_d;
        inst_t     inst_q;
        fu_op_e    op_q;
        tag_t      dest_tag_q;

        // pick the operand source at dispatch
        function automatic opnd_t capture(input tag_t tag, input logic rdy, input data_t rf_value,
                                          input data_t rob_value, input cdb_packet_t cdb);
                opnd_t o;
                o.tag   = tag;
                o.valid = 1'b1;
                o.value = rf_value;
                if (tag == '0) begin
                        o.value = rf_value;
                end else if (rdy) begin
                        o.value = rob_value;
                end else if (cdb.valid && cdb.reg_tag == tag) begin
                        o.value = cdb.reg_value;
                end else begin
                        o.valid = 1'b0;
                        o.value = '0;
                end
                return o;
        endfunction

        function automatic opnd_t wake(input opnd_t o_in, input cdb_packet_t cdb);
                opnd_t o;
                o = o_in;
                if (!o.valid && cdb.valid && cdb.reg_tag == o.tag) begin
                        o.valid = 1'b1;
                        o.value = cdb.reg_value;
                end
                return o;
        endfunction

        always_comb begin
                opnd1_d = opnd1_q;
                opnd2_d = opnd2_q;
                state_d = state_q;
                if (load) begin
                        opnd1_d = capture(mt2rs_packet.rs1_tag, mt2rs_packet.rs1_ready,
                                          id_packet.rs1_value, rob2rs_packet.rs1_value, cdb_packet);
                        opnd2_d = capture(mt2rs_packet.rs2_tag, mt2rs_packet.rs2_ready,
                                          id_packet.rs2_value, rob2rs_packet.rs2_value, cdb_packet);
                end else if (state_q == RS_WAITING) begin
                        opnd1_d = wake(opnd1_q, cdb_packet);
                        opnd2_d = wake(opnd2_q, cdb_packet);
                end
                unique case (state_q)
                        RS_FREE: begin
                                if (load) begin
                                        state_d = (opnd1_d.valid && opnd2_d.valid) ?
                                                  RS_READY : RS_WAITING;
                                end
                        end
                        RS_WAITING: begin
                                if (opnd1_d.valid && opnd2_d.valid) begin
                                        state_d = RS_READY;
                                end
                        end
                        RS_READY: begin
                                if (clear) begin
                                        state_d = RS_FREE;
                                end
                        end
                        default: state_d = RS_FREE;
                endcase
        end

        always_ff @(posedge clock) begin
                if (rst) begin
                        state_q <= RS_FREE;
                end else begin
                        state_q <= state_d;
                end
        end

        always_ff @(posedge clock) begin
                opnd1_q <= opnd1_d;
                opnd2_q <= opnd2_d;
                if (load) begin
                        inst_q     <= id_packet.inst;
                        op_q       <= id_packet.op;
                        dest_tag_q <= rob2rs_packet.rob_entry;
                end
        end

        assign busy  = (state_q != RS_FREE);
        assign ready = (state_q == RS_READY);

        assign entry_packet.valid     = ready;
        assign entry_packet.inst      = inst_q;
        assign entry_packet.op        = op_q;
        assign entry_packet.rs1_value = opnd1_q.value;
        assign entry_packet.rs2_value = opnd2_q.value;
        assign entry_packet.dest_tag  = dest_tag_q;

        // station allocation and issue select must respect slot state
        a_load_free: assert property (@(posedge clock) disable iff (rst) load |-> !busy);
        a_clear_ready: assert property (@(posedge clock) disable iff (rst) clear |-> ready);

endmodule

`default_nettype wire

//--- hw/map_table.sv
`default_nettype none

`include "rs_defines.svh"

module map_table (
        input  logic                    clock,
        input  logic                    rst,
        input  logic                    dispatch_fire,
        input  ooo_pkg::id_packet_t     id_packet,
        input  ooo_pkg::tag_t           rob_tag,
        input  ooo_pkg::cdb_packet_t    cdb_packet,
        input  ooo_pkg::retire_packet_t retire_packet,
        output ooo_pkg::mt2rs_packet_t  mt2rs_packet
);

        import isa_pkg::*;
        import ooo_pkg::*;

        tag_t [`NUM_REGS-1:0] tag_q;
        logic [`NUM_REGS-1:0] ready_q;

        // register 0 is never renamed and always reads tag 0
        always_comb begin
                mt2rs_packet.rs1_tag   = tag_q[id_packet.rs1_idx];
                mt2rs_packet.rs2_tag   = tag_q[id_packet.rs2_idx];
                mt2rs_packet.rs1_ready = ready_q[id_packet.rs1_idx];
                mt2rs_packet.rs2_ready = ready_q[id_packet.rs2_idx];
        end

        always_ff @(posedge clock) begin
                if (rst) begin
                        tag_q   <= '0;
                        ready_q <= '1;
                end else begin
                        for (int i = 1; i < `NUM_REGS; i++) begin
                                // wakeup
                                if (cdb_packet.valid && tag_q[i] == cdb_packet.reg_tag) begin
                                        ready_q[i] <= 1'b1;
                                end
                                // only clear if no younger rename took the register
                                if (retire_packet.valid && retire_packet.reg_idx == reg_idx_t'(i)
                                    && tag_q[i] == retire_packet.tag) begin
                                        tag_q[i]   <= '0;
                                        ready_q[i] <= 1'b1;
                                end
                                // rename last so it wins over retire
                                if (dispatch_fire && id_packet.dest_reg_idx == reg_idx_t'(i)) begin
                                        tag_q[i]   <= rob_tag;
                                        ready_q[i] <= 1'b0;
                                end
                        end
                end
        end

        // the rob must never hand out the register file tag
        a_no_tag_zero: assert property (@(posedge clock) disable iff (rst)
                dispatch_fire |-> rob_tag != '0);

endmodule

`default_nettype wire

//--- hw/ooo_pkg.sv
`default_nettype none

`include "rs_defines.svh"

package ooo_pkg;

        import isa_pkg::*;

        typedef logic [`TAG_W-1:0] tag_t;

        typedef enum logic [1:0] {
                RS_FREE    = 2'd0,
                RS_WAITING = 2'd1,
                RS_READY   = 2'd2
        } rs_state_e;

        // decoded instruction with register file reads
        typedef struct packed {
                inst_t    inst;
                fu_op_e   op;
                reg_idx_t rs1_idx;
                reg_idx_t rs2_idx;
                reg_idx_t dest_reg_idx;
                data_t    rs1_value;
                data_t    rs2_value;
        } id_packet_t;

        // rob_entry is the tag being allocated for this dispatch
        typedef struct packed {
                tag_t  rob_entry;
                data_t rs1_value;
                data_t rs2_value;
        } rob2rs_packet_t;

        typedef struct packed {
                logic  valid;
                tag_t  reg_tag;
                data_t reg_value;
        } cdb_packet_t;

        typedef struct packed {
                tag_t rs1_tag;
                tag_t rs2_tag;
                logic rs1_ready;
                logic rs2_ready;
        } mt2rs_packet_t;

        typedef struct packed {
                logic     valid;
                reg_idx_t reg_idx;
                tag_t     tag;
        } retire_packet_t;

        typedef struct packed {
                logic   valid;
                inst_t  inst;
                fu_op_e op;
                data_t  rs1_value;
                data_t  rs2_value;
                tag_t   dest_tag;
        } is_packet_t;

endpackage

`default_nettype wire

//--- hw/isa_pkg.sv
`default_nettype none

`include "rs_defines.svh"

package isa_pkg;

        typedef logic [`XLEN-1:0] data_t;

        typedef logic [`REG_W-1:0] reg_idx_t;

        // raw instruction word from decode
        typedef logic [31:0] inst_t;

        // operations understood by the single functional unit
        typedef enum logic [2:0] {
                FU_ADD = 3'd0,
                FU_SUB = 3'd1,
                FU_AND = 3'd2,
                FU_OR  = 3'd3,
                FU_XOR = 3'd4,
                FU_SLL = 3'd5,
                FU_SRL = 3'd6,
                FU_SLT = 3'd7
        } fu_op_e;

endpackage

`default_nettype wire

//--- include/rs_defines.svh
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// station depth and index width
`define RS_LEN 8
`define RS_IDX_W 3

// reorder buffer, tag 0 means the value sits in the register file
`define ROB_LEN 16
`define TAG_W 4

// architectural state
`define XLEN 32
`define NUM_REGS 32
`define REG_W 5

`endif
